//--- list.f
+incdir+tb
common/isa_pkg.sv
common/ooo_pkg.sv
source/decoder.sv
dispatch/map_table.sv
dispatch/dispatcher.sv
source/reservation_station.sv
source/execute_unit.sv
source/reorder_buffer.sv
source/register_file.sv
source/ooo_core.sv
tb/ooo_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the ooo_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module ooo_core_tb -o ooo_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/ooo_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0

//--- tb/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

localparam logic [6:0] OPCODE_REG = 7'b0110011;
localparam logic [6:0] OPCODE_IMM = 7'b0010011;
// a load opcode, outside the supported subset
localparam logic [6:0] OPCODE_LOAD = 7'b0000011;

localparam logic [6:0] FN7_BASE = 7'b0000000;
localparam logic [6:0] FN7_ALT = 7'b0100000;
localparam logic [6:0] FN7_MUL = 7'b0000001;
localparam logic [2:0] FN3_ADD = 3'b000;
localparam logic [2:0] FN3_SLT = 3'b010;
localparam logic [2:0] FN3_XOR = 3'b100;
localparam logic [2:0] FN3_OR = 3'b110;
localparam logic [2:0] FN3_AND = 3'b111;

typedef struct packed {
    logic [4:0] rd;
    logic [31:0] value;
    logic [31:0] pc;
} expect_t;

logic [31:0] model_regs [32];
expect_t exp_q [$];
logic [31:0] rng_state;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPCODE_REG};
endfunction

function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OPCODE_IMM};
endfunction

function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// runs one word in program order and queues the commit it must produce
function automatic void model_step(input logic [31:0] word, input logic [31:0] pc);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] result;
    logic known;
    logic [4:0] rd;
    expect_t e;
    a = model_regs[word[19:15]];
    b = model_regs[word[24:20]];
    imm = {{20{word[31]}}, word[31:20]};
    known = 1'b1;
    result = '0;
    if (word[6:0] == OPCODE_REG) begin
        case ({word[31:25], word[14:12]})
            {FN7_BASE, FN3_ADD}: result = a + b;
            {FN7_ALT, FN3_ADD}: result = a - b;
            {FN7_BASE, FN3_SLT}: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            {FN7_BASE, FN3_XOR}: result = a ^ b;
            {FN7_BASE, FN3_OR}: result = a | b;
            {FN7_BASE, FN3_AND}: result = a & b;
            {FN7_MUL, FN3_ADD}: result = a * b;
            default: known = 1'b0;
        endcase
    end else if (word[6:0] == OPCODE_IMM) begin
        case (word[14:12])
            FN3_ADD: result = a + imm;
            FN3_XOR: result = a ^ imm;
            FN3_OR: result = a | imm;
            FN3_AND: result = a & imm;
            default: known = 1'b0;
        endcase
    end else begin
        known = 1'b0;
    end
    // anything else retires as a nop into x0
    rd = known ? word[11:7] : 5'd0;
    if (!known) begin
        result = '0;
    end
    if (rd != 5'd0) begin
        model_regs[rd] = result;
    end
    e.rd = rd;
    e.value = result;
    e.pc = pc;
    exp_q.push_back(e);
endfunction

`endif

//--- tb/ooo_core_tb.sv
module ooo_core_tb;

    localparam int STALL_LIMIT = 100;
    localparam int DRAIN_LIMIT = 300;

    logic clk;
    logic reset;
    logic inst_valid;
    isa_pkg::inst_word_u inst;
    logic [31:0] inst_pc;
    logic stall;
    ooo_pkg::commit_t commit;

    `include "core_model.svh"

    logic [31:0] next_pc;
    expect_t expected_head;
    int errors;
    int sent_count;
    int commit_count;
    logic stall_seen;
    logic aborted;

    ooo_core #(.ALU_RS_DEPTH(4), .MUL_RS_DEPTH(2)) uut (
        .clk(clk),
        .reset(reset),
        .inst_valid(inst_valid),
        .inst(inst),
        .inst_pc(inst_pc),
        .stall(stall),
        .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    // later sends and drains are skipped once a wait has run out
    task automatic report_timeout(input string why);
        $display("Error at %0t: %s", $time, why);
        errors++;
        aborted = 1'b1;
    endtask

    // every commit is compared with the oldest expected one
    always @(negedge clk) begin
        if (!reset) begin
            if (stall) begin
                stall_seen = 1'b1;
            end
            if (commit.valid) begin
                commit_count++;
                assert (exp_q.size() > 0) else begin
                    $display("Error at %0t: commit of pc %h with nothing outstanding",
                             $time, commit.pc);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    expected_head = exp_q.pop_front();
                    check_value("commit.pc", commit.pc, expected_head.pc);
                    check_value("commit.rd", 32'(commit.rd), 32'(expected_head.rd));
                    check_value("commit.value", commit.value, expected_head.value);
                end
            end
        end
    end

    // held until stall is low at a falling edge
    task automatic send_inst(input logic [31:0] word);
        int waits;
        waits = 0;
        if (!aborted) begin
            inst_valid = 1'b1;
            inst = word;
            inst_pc = next_pc;
            model_step(word, next_pc);
            next_pc = next_pc + 32'd4;
            sent_count++;
            while (stall && waits < STALL_LIMIT) begin
                @(negedge clk);
                waits++;
            end
            if (stall) begin
                report_timeout("stall stayed high and the instruction was never taken");
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic issue_r(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2);
        send_inst(enc_r(f7, f3, rd, rs1, rs2));
    endtask

    task automatic issue_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] imm);
        send_inst(enc_i(f3, rd, rs1, imm));
    endtask

    task automatic idle_cycles(input int n);
        inst_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic close_test(input string name, input int start_errors);
        int waits;
        waits = 0;
        inst_valid = 1'b0;
        while (!aborted && exp_q.size() != 0 && waits < DRAIN_LIMIT) begin
            @(negedge clk);
            waits++;
        end
        if (!aborted && exp_q.size() != 0) begin
            report_timeout("outstanding instructions never committed");
        end
        $display("%s: %0d errors", name, errors - start_errors);
    endtask

    task automatic reset_behavior;
        int start;
        start = errors;
        reset = 1'b1;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_value("stall", 32'(stall), 32'd0);
            check_value("commit.valid", 32'(commit.valid), 32'd0);
        end
        reset = 1'b0;
        // no instruction sent, so the monitor must stay quiet
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            check_value("stall", 32'(stall), 32'd0);
            check_value("commit.valid", 32'(commit.valid), 32'd0);
        end
        close_test("reset", start);
    endtask

    task automatic independent_ops;
        int start;
        start = errors;
        issue_i(FN3_ADD, 5'd1, 5'd0, 12'd5);
        issue_i(FN3_ADD, 5'd2, 5'd0, 12'hffd);
        issue_i(FN3_ADD, 5'd3, 5'd0, 12'h7ff);
        issue_r(FN7_BASE, FN3_ADD, 5'd4, 5'd1, 5'd2);
        issue_r(FN7_ALT, FN3_ADD, 5'd5, 5'd1, 5'd2);
        issue_r(FN7_BASE, FN3_AND, 5'd6, 5'd2, 5'd3);
        issue_r(FN7_BASE, FN3_OR, 5'd7, 5'd1, 5'd2);
        issue_r(FN7_BASE, FN3_XOR, 5'd8, 5'd2, 5'd3);
        // signed compare both ways
        issue_r(FN7_BASE, FN3_SLT, 5'd9, 5'd2, 5'd1);
        issue_r(FN7_BASE, FN3_SLT, 5'd10, 5'd1, 5'd2);
        issue_i(FN3_AND, 5'd11, 5'd2, 12'h0f0);
        issue_i(FN3_OR, 5'd12, 5'd1, 12'h800);
        issue_i(FN3_XOR, 5'd13, 5'd3, 12'hfff);
        issue_i(FN3_ADD, 5'd0, 5'd1, 12'd9);
        send_inst({25'h1abcd, OPCODE_LOAD});
        issue_r(FN7_BASE, FN3_ADD, 5'd14, 5'd0, 5'd0);
        close_test("independent ops", start);
    endtask

    task automatic dependent_chains;
        int start;
        start = errors;
        issue_i(FN3_ADD, 5'd6, 5'd0, 12'd10);
        issue_r(FN7_BASE, FN3_ADD, 5'd7, 5'd6, 5'd6);
        issue_r(FN7_ALT, FN3_ADD, 5'd8, 5'd7, 5'd6);
        issue_r(FN7_BASE, FN3_XOR, 5'd6, 5'd8, 5'd7);
        issue_i(FN3_ADD, 5'd6, 5'd6, 12'hfff);
        // the multiply holds the head while x13 finishes behind it
        issue_r(FN7_MUL, FN3_ADD, 5'd12, 5'd6, 5'd7);
        issue_i(FN3_ADD, 5'd13, 5'd0, 12'd4);
        idle_cycles(2);
        issue_r(FN7_BASE, FN3_ADD, 5'd14, 5'd13, 5'd13);
        idle_cycles(10);
        issue_r(FN7_BASE, FN3_AND, 5'd9, 5'd6, 5'd8);
        issue_r(FN7_BASE, FN3_SLT, 5'd10, 5'd12, 5'd14);
        close_test("dependent chains", start);
    endtask

    task automatic out_of_order;
        int start;
        start = errors;
        issue_r(FN7_MUL, FN3_ADD, 5'd15, 5'd1, 5'd2);
        issue_i(FN3_ADD, 5'd16, 5'd0, 12'd1);
        issue_r(FN7_BASE, FN3_XOR, 5'd17, 5'd1, 5'd3);
        issue_r(FN7_MUL, FN3_ADD, 5'd18, 5'd15, 5'd3);
        issue_r(FN7_BASE, FN3_OR, 5'd19, 5'd16, 5'd17);
        issue_r(FN7_BASE, FN3_ADD, 5'd20, 5'd18, 5'd16);
        issue_r(FN7_ALT, FN3_ADD, 5'd21, 5'd15, 5'd19);
        close_test("out of order", start);
    endtask

    task automatic back_pressure;
        int start;
        int start_sent;
        int start_commits;
        start = errors;
        start_sent = sent_count;
        start_commits = commit_count;
        stall_seen = 1'b0;
        issue_i(FN3_ADD, 5'd20, 5'd0, 12'd3);
        issue_i(FN3_ADD, 5'd21, 5'd0, 12'd5);
        repeat (10) issue_r(FN7_MUL, FN3_ADD, 5'd20, 5'd20, 5'd21);
        issue_r(FN7_BASE, FN3_ADD, 5'd22, 5'd20, 5'd21);
        close_test("back pressure", start);
        assert (stall_seen) else begin
            $display("Error at %0t: stall never went high during the burst", $time);
            errors++;
        end
        check_value("commit count", 32'(commit_count - start_commits),
                    32'(sent_count - start_sent));
    endtask

    task automatic random_program;
        int start;
        logic [31:0] word;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        start = errors;
        rng_state = 32'ha718_26d3;
        for (int i = 0; i < 200; i++) begin
            rng_state = xorshift(rng_state);
            // small register range keeps dependencies frequent
            rd = {2'b00, rng_state[10:8]};
            rs1 = {2'b00, rng_state[13:11]};
            rs2 = {2'b00, rng_state[16:14]};
            case (rng_state[7:0] % 13)
                0: word = enc_r(FN7_BASE, FN3_ADD, rd, rs1, rs2);
                1: word = enc_r(FN7_ALT, FN3_ADD, rd, rs1, rs2);
                2: word = enc_r(FN7_BASE, FN3_AND, rd, rs1, rs2);
                3: word = enc_r(FN7_BASE, FN3_OR, rd, rs1, rs2);
                4: word = enc_r(FN7_BASE, FN3_XOR, rd, rs1, rs2);
                5: word = enc_r(FN7_BASE, FN3_SLT, rd, rs1, rs2);
                6: word = enc_r(FN7_MUL, FN3_ADD, rd, rs1, rs2);
                7: word = enc_i(FN3_ADD, rd, rs1, rng_state[28:17]);
                8: word = enc_i(FN3_AND, rd, rs1, rng_state[28:17]);
                9: word = enc_i(FN3_OR, rd, rs1, rng_state[28:17]);
                10: word = enc_i(FN3_XOR, rd, rs1, rng_state[28:17]);
                11: word = {rng_state[31:7], OPCODE_LOAD};
                default: word = enc_i(FN3_SLT, rd, rs1, rng_state[28:17]);
            endcase
            send_inst(word);
            if (rng_state[31:29] == 3'd0) begin
                idle_cycles(1);
            end
        end
        close_test("random program", start);
    endtask

    initial begin
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        inst_pc = '0;
        next_pc = 32'h0000_1000;
        errors = 0;
        sent_count = 0;
        commit_count = 0;
        stall_seen = 1'b0;
        aborted = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        reset_behavior();
        independent_ops();
        dependent_chains();
        out_of_order();
        back_pressure();
        random_program();
        $display("6 tests, %0d sent, %0d committed, %0d errors", sent_count, commit_count,
                 errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- source/ooo_core.sv
module ooo_core #(
    parameter int ALU_RS_DEPTH = 4,
    parameter int MUL_RS_DEPTH = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic inst_valid,
    input  isa_pkg::inst_word_u inst,
    input  logic [isa_pkg::XLEN-1:0] inst_pc,
    output logic stall,
    output ooo_pkg::commit_t commit
);
    import isa_pkg::*;
    import ooo_pkg::*;

    decoded_pack_t decoded_pack;
    logic [REG_NUM-1:0][XLEN-1:0] registers;
    rob_entry_t [ROB_SIZE-1:0] rob;
    logic [ROB_TAG_LEN-1:0] alloc_tag;
    logic rob_full;
    cdb_t cdb;
    logic [1:0] rs_full;
    logic [1:0] rs_load;
    rs_entry_t rs_entry;
    rob_alloc_t rob_alloc;
    logic alu_issue_enable;
    logic alu_issue_valid;
    logic mul_issue_valid;
    rs_entry_t alu_issue_entry;
    rs_entry_t mul_issue_entry;

    decoder decoder_i (
        .inst(inst),
        .inst_pc(inst_pc),
        .inst_valid(inst_valid),
        .decoded_pack(decoded_pack)
    );

    dispatcher dispatcher_i (
        .clk(clk),
        .reset(reset),
        .decoded_pack(decoded_pack),
        .registers(registers),
        .rob(rob),
        .alloc_tag(alloc_tag),
        .rob_full(rob_full),
        .cdb(cdb),
        .commit(commit),
        .rs_full(rs_full),
        .rs_entry(rs_entry),
        .rs_load(rs_load),
        .rob_alloc(rob_alloc),
        .stall(stall)
    );

    reservation_station #(.RS_DEPTH(ALU_RS_DEPTH)) alu_rs (
        .clk(clk),
        .reset(reset),
        .load(rs_load[FU_ALU]),
        .entry_in(rs_entry),
        .cdb(cdb),
        .issue_enable(alu_issue_enable),
        .full(rs_full[FU_ALU]),
        .issue_valid(alu_issue_valid),
        .issue_entry(alu_issue_entry)
    );

    // multiplier always owns the cdb when it has a result
    reservation_station #(.RS_DEPTH(MUL_RS_DEPTH)) mul_rs (
        .clk(clk),
        .reset(reset),
        .load(rs_load[FU_MUL]),
        .entry_in(rs_entry),
        .cdb(cdb),
        .issue_enable(1'b1),
        .full(rs_full[FU_MUL]),
        .issue_valid(mul_issue_valid),
        .issue_entry(mul_issue_entry)
    );

    execute_unit execute_unit_i (
        .clk(clk),
        .reset(reset),
        .alu_valid(alu_issue_valid),
        .alu_entry(alu_issue_entry),
        .mul_valid(mul_issue_valid),
        .mul_entry(mul_issue_entry),
        .alu_issue_enable(alu_issue_enable),
        .cdb(cdb)
    );

    reorder_buffer reorder_buffer_i (
        .clk(clk),
        .reset(reset),
        .rob_alloc(rob_alloc),
        .cdb(cdb),
        .alloc_tag(alloc_tag),
        .full(rob_full),
        .rob(rob),
        .commit(commit)
    );

    register_file register_file_i (
        .clk(clk),
        .reset(reset),
        .commit(commit),
        .registers(registers)
    );

endmodule

//--- source/register_file.sv
module register_file (
    input  logic clk,
    input  logic reset,
    input  ooo_pkg::commit_t commit,
    output logic [isa_pkg::REG_NUM-1:0][isa_pkg::XLEN-1:0] registers
);
    import isa_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            registers <= '0;
        end else if (commit.valid && commit.rd != '0) begin
            // x0 stays zero
            registers[commit.rd] <= commit.value;
        end
    end

endmodule

//--- source/reorder_buffer.sv
module reorder_buffer (
    input  logic clk,
    input  logic reset,
    input  ooo_pkg::rob_alloc_t rob_alloc,
    input  ooo_pkg::cdb_t cdb,
    output logic [ooo_pkg::ROB_TAG_LEN-1:0] alloc_tag,
    output logic full,
    output ooo_pkg::rob_entry_t [ooo_pkg::ROB_SIZE-1:0] rob,
    output ooo_pkg::commit_t commit
);
    import ooo_pkg::*;

    logic [ROB_TAG_LEN-1:0] head;
    logic [ROB_TAG_LEN-1:0] tail;
    logic [ROB_TAG_LEN:0] count;

    assign alloc_tag = tail;
    assign full = (count == ROB_SIZE);

    // head retires as soon as its result is in
    assign commit.valid = rob[head].busy && rob[head].done;
    assign commit.rd = rob[head].dest;
    assign commit.value = rob[head].value;
    assign commit.pc = rob[head].pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            for (int i = 0; i < ROB_SIZE; i++) begin
                rob[i].busy <= 1'b0;
                rob[i].done <= 1'b0;
            end
        end else begin
            if (commit.valid) begin
                rob[head].busy <= 1'b0;
                head <= head + 1'b1;
            end
            if (cdb.valid) begin
                rob[cdb.tag].done <= 1'b1;
                rob[cdb.tag].value <= cdb.value;
            end
            if (rob_alloc.valid) begin
                rob[tail].busy <= 1'b1;
                rob[tail].done <= 1'b0;
                rob[tail].dest <= rob_alloc.dest;
                rob[tail].pc <= rob_alloc.pc;
                tail <= tail + 1'b1;
            end
            count <= count + (ROB_TAG_LEN+1)'(rob_alloc.valid)
                           - (ROB_TAG_LEN+1)'(commit.valid);
        end
    end

endmodule

//--- source/execute_unit.sv
module execute_unit (
    input  logic clk,
    input  logic reset,
    input  logic alu_valid,
    input  ooo_pkg::rs_entry_t alu_entry,
    input  logic mul_valid,
    input  ooo_pkg::rs_entry_t mul_entry,
    output logic alu_issue_enable,
    output ooo_pkg::cdb_t cdb
);
    import isa_pkg::*;
    import ooo_pkg::*;

    logic [XLEN-1:0] alu_result;
    logic m1_valid;
    logic m2_valid;
    logic [ROB_TAG_LEN-1:0] m1_tag;
    logic [ROB_TAG_LEN-1:0] m2_tag;
    logic [XLEN-1:0] m1_a;
    logic [XLEN-1:0] m1_b;
    logic [XLEN-1:0] m2_product;

    always_comb begin
        case (alu_entry.func)
            ALU_SUB: alu_result = alu_entry.src1.value - alu_entry.src2.value;
            ALU_AND: alu_result = alu_entry.src1.value & alu_entry.src2.value;
            ALU_OR: alu_result = alu_entry.src1.value | alu_entry.src2.value;
            ALU_XOR: alu_result = alu_entry.src1.value ^ alu_entry.src2.value;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}},
                $signed(alu_entry.src1.value) < $signed(alu_entry.src2.value)};
            default: alu_result = alu_entry.src1.value + alu_entry.src2.value;
        endcase
    end

    // m2 drives the cdb next edge, so keep the alu off it
    assign alu_issue_enable = !m2_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            m1_valid <= 1'b0;
            m2_valid <= 1'b0;
            cdb.valid <= 1'b0;
        end else begin
            m1_valid <= mul_valid;
            m2_valid <= m1_valid;
            cdb.valid <= m2_valid || alu_valid;
        end
        m1_tag <= mul_entry.tag_dest;
        m1_a <= mul_entry.src1.value;
        m1_b <= mul_entry.src2.value;
        m2_tag <= m1_tag;
        // low half of the product only
        m2_product <= m1_a * m1_b;
        if (m2_valid) begin
            cdb.tag <= m2_tag;
            cdb.value <= m2_product;
        end else begin
            cdb.tag <= alu_entry.tag_dest;
            cdb.value <= alu_result;
        end
    end

endmodule

//--- source/reservation_station.sv
module reservation_station #(
    parameter int RS_DEPTH = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic load,
    input  ooo_pkg::rs_entry_t entry_in,
    input  ooo_pkg::cdb_t cdb,
    input  logic issue_enable,
    output logic full,
    output logic issue_valid,
    output ooo_pkg::rs_entry_t issue_entry
);
    import ooo_pkg::*;

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    // slot 0 is the oldest and the queue compacts on issue
    rs_entry_t slots [RS_DEPTH];
    rs_entry_t slots_next [RS_DEPTH];
    logic [CNT_W-1:0] count;
    logic [IDX_W-1:0] pick;
    logic ready_found;

    function automatic operand_t snoop(input operand_t op, input cdb_t bus);
        if (!op.ready && bus.valid && bus.tag == op.tag) begin
            op.ready = 1'b1;
            op.value = bus.value;
        end
        return op;
    endfunction

    // lowest index wins, so scan from the top
    always_comb begin
        ready_found = 1'b0;
        pick = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (i < int'(count) && slots[i].src1.ready && slots[i].src2.ready) begin
                ready_found = 1'b1;
                pick = IDX_W'(i);
            end
        end
    end

    assign issue_valid = ready_found && issue_enable;
    assign issue_entry = slots[pick];
    assign full = (count == RS_DEPTH);

    always_comb begin
        int src;
        int pos;
        for (int i = 0; i < RS_DEPTH; i++) begin
            src = (issue_valid && i >= int'(pick)) ? i + 1 : i;
            if (src < RS_DEPTH) begin
                slots_next[i] = slots[src];
            end else begin
                slots_next[i] = slots[i];
            end
            slots_next[i].src1 = snoop(slots_next[i].src1, cdb);
            slots_next[i].src2 = snoop(slots_next[i].src2, cdb);
        end
        // new entry goes behind the survivors
        pos = int'(count) - int'(issue_valid);
        if (load && pos < RS_DEPTH) begin
            slots_next[pos] = entry_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(load) - CNT_W'(issue_valid);
        end
    end

    always_ff @(posedge clk) begin
        slots <= slots_next;
    end

endmodule

//--- dispatch/dispatcher.sv
module dispatcher (
    input  logic clk,
    input  logic reset,
    input  isa_pkg::decoded_pack_t decoded_pack,
    input  logic [isa_pkg::REG_NUM-1:0][isa_pkg::XLEN-1:0] registers,
    input  ooo_pkg::rob_entry_t [ooo_pkg::ROB_SIZE-1:0] rob,
    input  logic [ooo_pkg::ROB_TAG_LEN-1:0] alloc_tag,
    input  logic rob_full,
    input  ooo_pkg::cdb_t cdb,
    input  ooo_pkg::commit_t commit,
    input  logic [1:0] rs_full,
    output ooo_pkg::rs_entry_t rs_entry,
    output logic [1:0] rs_load,
    output ooo_pkg::rob_alloc_t rob_alloc,
    output logic stall
);
    import isa_pkg::*;
    import ooo_pkg::*;

    decoded_pack_t held;
    map_stat_t src1_stat;
    map_stat_t src2_stat;
    logic dispatch;

    // unmapped -> regfile, done -> rob, else catch it on the cdb
    function automatic operand_t source(input map_stat_t stat, input logic [XLEN-1:0] reg_val,
                                        input logic [XLEN-1:0] rob_val, input cdb_t bus);
        operand_t op;
        op.tag = stat.tag;
        op.ready = 1'b1;
        if (!stat.mapped) begin
            op.value = reg_val;
        end else if (stat.done) begin
            op.value = rob_val;
        end else if (bus.valid && bus.tag == stat.tag) begin
            op.value = bus.value;
        end else begin
            op.ready = 1'b0;
            op.value = '0;
        end
        return op;
    endfunction

    // held pack stays put while stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            held.valid <= 1'b0;
        end else if (!stall) begin
            held <= decoded_pack;
        end
    end

    map_table map_table_i (
        .clk(clk),
        .reset(reset),
        .rs1(held.rs1),
        .rs2(held.rs2),
        .rd(held.rd),
        .assign_flag(dispatch),
        .alloc_tag(alloc_tag),
        .cdb(cdb),
        .commit(commit),
        .src1_stat(src1_stat),
        .src2_stat(src2_stat)
    );

    always_comb begin
        rs_entry.fu = held.fu;
        rs_entry.func = held.alu_func;
        rs_entry.tag_dest = alloc_tag;
        rs_entry.src1 = source(src1_stat, registers[held.rs1], rob[src1_stat.tag].value, cdb);
        if (held.imm_valid) begin
            rs_entry.src2.ready = 1'b1;
            rs_entry.src2.tag = '0;
            rs_entry.src2.value = held.imm;
        end else begin
            rs_entry.src2 = source(src2_stat, registers[held.rs2], rob[src2_stat.tag].value,
                                   cdb);
        end
    end

    assign stall = held.valid && (rs_full[held.fu] || rob_full);
    assign dispatch = held.valid && !stall;

    always_comb begin
        rs_load = '0;
        rs_load[held.fu] = dispatch;
    end

    assign rob_alloc.valid = dispatch;
    assign rob_alloc.dest = held.rd;
    assign rob_alloc.pc = held.pc;

endmodule

//--- dispatch/map_table.sv
module map_table (
    input  logic clk,
    input  logic reset,
    input  logic [isa_pkg::REG_ADDR_LEN-1:0] rs1,
    input  logic [isa_pkg::REG_ADDR_LEN-1:0] rs2,
    input  logic [isa_pkg::REG_ADDR_LEN-1:0] rd,
    input  logic assign_flag,
    input  logic [ooo_pkg::ROB_TAG_LEN-1:0] alloc_tag,
    input  ooo_pkg::cdb_t cdb,
    input  ooo_pkg::commit_t commit,
    output ooo_pkg::map_stat_t src1_stat,
    output ooo_pkg::map_stat_t src2_stat
);
    import isa_pkg::*;
    import ooo_pkg::*;

    map_stat_t map [REG_NUM];
    // follows the rob head since commits retire tags in order
    logic [ROB_TAG_LEN-1:0] retire_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_tag <= '0;
            for (int i = 0; i < REG_NUM; i++) begin
                map[i].mapped <= 1'b0;
                map[i].done <= 1'b0;
            end
        end else begin
            if (commit.valid) begin
                retire_tag <= retire_tag + 1'b1;
                // only drop it if no younger producer took over
                if (map[commit.rd].mapped && map[commit.rd].tag == retire_tag) begin
                    map[commit.rd].mapped <= 1'b0;
                end
            end
            for (int i = 0; i < REG_NUM; i++) begin
                if (cdb.valid && map[i].mapped && map[i].tag == cdb.tag) begin
                    map[i].done <= 1'b1;
                end
            end
            // x0 never gets renamed
            if (assign_flag && rd != '0) begin
                map[rd].mapped <= 1'b1;
                map[rd].done <= 1'b0;
                map[rd].tag <= alloc_tag;
            end
        end
    end

    assign src1_stat = map[rs1];
    assign src2_stat = map[rs2];

endmodule

//--- source/decoder.sv
module decoder (
    input  isa_pkg::inst_word_u inst,
    input  logic [isa_pkg::XLEN-1:0] inst_pc,
    input  logic inst_valid,
    output isa_pkg::decoded_pack_t decoded_pack
);
    import isa_pkg::*;

    always_comb begin
        logic known;
        known = 1'b1;
        // defaults form add x0, x0, 0
        decoded_pack.valid = inst_valid;
        decoded_pack.pc = inst_pc;
        decoded_pack.fu = FU_ALU;
        decoded_pack.alu_func = ALU_ADD;
        decoded_pack.rd = '0;
        decoded_pack.rs1 = '0;
        decoded_pack.rs2 = '0;
        decoded_pack.imm = '0;
        decoded_pack.imm_valid = 1'b1;
        case (inst.r_fields.opcode)
            OPC_OP: begin
                case ({inst.r_fields.funct7, inst.r_fields.funct3})
                    {F7_BASE, F3_ADD_SUB}: decoded_pack.alu_func = ALU_ADD;
                    {F7_SUB, F3_ADD_SUB}: decoded_pack.alu_func = ALU_SUB;
                    {F7_BASE, F3_SLT}: decoded_pack.alu_func = ALU_SLT;
                    {F7_BASE, F3_XOR}: decoded_pack.alu_func = ALU_XOR;
                    {F7_BASE, F3_OR}: decoded_pack.alu_func = ALU_OR;
                    {F7_BASE, F3_AND}: decoded_pack.alu_func = ALU_AND;
                    {F7_MULDIV, F3_ADD_SUB}: decoded_pack.fu = FU_MUL;
                    default: known = 1'b0;
                endcase
                if (known) begin
                    decoded_pack.rd = inst.r_fields.rd;
                    decoded_pack.rs1 = inst.r_fields.rs1;
                    decoded_pack.rs2 = inst.r_fields.rs2;
                    decoded_pack.imm_valid = 1'b0;
                end
            end
            OPC_OP_IMM: begin
                case (inst.i_fields.funct3)
                    F3_ADD_SUB: decoded_pack.alu_func = ALU_ADD;
                    F3_XOR: decoded_pack.alu_func = ALU_XOR;
                    F3_OR: decoded_pack.alu_func = ALU_OR;
                    F3_AND: decoded_pack.alu_func = ALU_AND;
                    default: known = 1'b0;
                endcase
                if (known) begin
                    decoded_pack.rd = inst.i_fields.rd;
                    decoded_pack.rs1 = inst.i_fields.rs1;
                    decoded_pack.imm = {{(XLEN-12){inst.i_fields.imm[11]}}, inst.i_fields.imm};
                end
            end
            default: known = 1'b0;
        endcase
    end

endmodule

//--- common/ooo_pkg.sv
package ooo_pkg;

    localparam int ROB_SIZE = 8;
    localparam int ROB_TAG_LEN = $clog2(ROB_SIZE);

    typedef struct packed {
        logic ready;
        logic [ROB_TAG_LEN-1:0] tag;
        logic [isa_pkg::XLEN-1:0] value;
    } operand_t;

    typedef struct packed {
        isa_pkg::fu_e fu;
        isa_pkg::alu_func_e func;
        logic [ROB_TAG_LEN-1:0] tag_dest;
        operand_t src1;
        operand_t src2;
    } rs_entry_t;

    typedef struct packed {
        logic valid;
        logic [isa_pkg::REG_ADDR_LEN-1:0] dest;
        logic [isa_pkg::XLEN-1:0] pc;
    } rob_alloc_t;

    typedef struct packed {
        logic valid;
        logic [ROB_TAG_LEN-1:0] tag;
        logic [isa_pkg::XLEN-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic [isa_pkg::REG_ADDR_LEN-1:0] dest;
        logic [isa_pkg::XLEN-1:0] pc;
        logic [isa_pkg::XLEN-1:0] value;
    } rob_entry_t;

    typedef struct packed {
        logic valid;
        logic [isa_pkg::REG_ADDR_LEN-1:0] rd;
        logic [isa_pkg::XLEN-1:0] value;
        logic [isa_pkg::XLEN-1:0] pc;
    } commit_t;

    // rename state of one architectural register
    typedef struct packed {
        logic mapped;
        logic done;
        logic [ROB_TAG_LEN-1:0] tag;
    } map_stat_t;

endpackage

//--- common/isa_pkg.sv
package isa_pkg;

    localparam int XLEN = 32;
    localparam int REG_NUM = 32;
    localparam int REG_ADDR_LEN = 5;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } i_fields_t;

    // one 32-bit word seen as R-type or I-type
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } inst_word_u;

    typedef enum logic [0:0] {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } fu_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_func_e;

    typedef struct packed {
        logic valid;
        fu_e fu;
        alu_func_e alu_func;
        logic [REG_ADDR_LEN-1:0] rd;
        logic [REG_ADDR_LEN-1:0] rs1;
        logic [REG_ADDR_LEN-1:0] rs2;
        logic [XLEN-1:0] imm;
        // second operand comes from imm
        logic imm_valid;
        logic [XLEN-1:0] pc;
    } decoded_pack_t;

endpackage
